// ==== cache_pkg.sv ====
/* Geometry and element types of the single-line instruction and data caches.
   Fetch addresses count nibbles, data addresses count bytes. */
package cache_pkg;

    // ========================================
    // Line geometry
    // ========================================
    localparam int LINE_BYTES = 4;

    typedef logic [LINE_BYTES*8-1:0] line_t;

    // ========================================
    // Elements and CPU addresses
    // ========================================
    typedef logic [3:0]  nibble_t;
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] if_addr_t;
    typedef logic [14:0] dm_addr_t;

    // Offset of an element inside one line
    localparam int IC_OFS_W = 3;
    localparam int DC_OFS_W = 2;

    // Tags are what is left of the address above the offset
    localparam int IC_TAG_W = $bits(if_addr_t) - IC_OFS_W;
    localparam int DC_TAG_W = $bits(dm_addr_t) - DC_OFS_W;

    typedef logic [IC_TAG_W-1:0] ic_tag_t;
    typedef logic [DC_TAG_W-1:0] dc_tag_t;

    // Code returned when no fetch completes
    localparam nibble_t CODE_NOP = 4'hf;

endpackage

// ==== bus_pkg.sv ====
/* External byte bus shared by both caches.
   Lower half of the address space holds code, upper half holds data. */
package bus_pkg;

    // ========================================
    // Bus widths
    // ========================================
    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    // Address bit that selects the data half
    localparam int REGION_DATA = 15;

    // ========================================
    // Bursts
    // ========================================
    // One beat per byte of a cache line
    localparam int BURST_LEN = 4;

    typedef logic [1:0] beat_t;

endpackage

// ==== cache_line.sv ====
/* One direct-mapped line with valid bit, tag and data.
   Load and merge must not be requested in the same cycle, and a merge needs a valid line. */
`timescale 1ns/10ps

module cache_line
#(
    parameter type elem_t = cache_pkg::byte_t,
    parameter type tag_t  = cache_pkg::dc_tag_t,
    localparam int ELEM_W = $bits(elem_t),
    localparam int ELEMS  = $bits(cache_pkg::line_t) / ELEM_W,
    localparam int OFS_W  = $clog2(ELEMS)
)
(
    input  logic              CLK,
    input  logic              RES,
    input  tag_t              req_tag,
    output logic              hit,
    output logic              valid,
    output tag_t              tag,
    input  logic [OFS_W-1:0]  offset,
    input  logic              load,
    input  tag_t              load_tag,
    input  cache_pkg::line_t  load_line,
    input  logic              merge,
    input  elem_t             merge_elem,
    output cache_pkg::line_t  line,
    output elem_t             elem
);

logic             valid_q;
tag_t             tag_q;
cache_pkg::line_t data_q;

// Valid and tag change only on a refill
always_ff @(posedge CLK, posedge RES)
begin
    if (RES)
    begin
        valid_q <= 1'b0;
        tag_q   <= '0;
    end
    else if (load)
    begin
        valid_q <= 1'b1;
        tag_q   <= load_tag;
    end
end

// Whole line on refill, one element on a write
always_ff @(posedge CLK)
begin
    if (load)
        data_q <= load_line;
    else if (merge)
        data_q[offset*ELEM_W +: ELEM_W] <= merge_elem;
end

assign hit   = valid_q & (tag_q == req_tag);
assign valid = valid_q;
assign tag   = tag_q;
assign line  = data_q;
assign elem  = data_q[offset*ELEM_W +: ELEM_W];

a_merge_valid : assert property (@(posedge CLK) disable iff (RES) merge |-> valid_q);
a_no_clash    : assert property (@(posedge CLK) disable iff (RES) !(load && merge));

endmodule

// ==== icache_ctrl.sv ====
/* Instruction fetch port, one request outstanding at a time.
   IF_CODE holds the NOP code outside the IF_RDY cycle. */
`timescale 1ns/10ps

module icache_ctrl
(
    input  logic                CLK,
    input  logic                RES,
    input  logic                IF_REQ,
    input  cache_pkg::if_addr_t IF_ADDR,
    output cache_pkg::nibble_t  IF_CODE,
    output logic                IF_RDY,
    output logic                ic_fill_req,
    output bus_pkg::bus_addr_t  ic_fill_addr,
    input  logic                ic_fill_done,
    input  cache_pkg::line_t    fill_line
);

typedef enum logic [1:0] {IC_IDLE, IC_HIT, IC_WAIT} state_t;

state_t              state;
logic                hit;
logic                accept;
cache_pkg::if_addr_t addr_q;
cache_pkg::nibble_t  elem;

assign accept = (state == IC_IDLE) & IF_REQ;

always_ff @(posedge CLK, posedge RES)
begin
    if (RES)
        state <= IC_IDLE;
    else
    begin
        case (state)
            IC_IDLE : if (IF_REQ) state <= hit ? IC_HIT : IC_WAIT;
            IC_HIT  : state <= IC_IDLE;
            IC_WAIT : if (ic_fill_done) state <= IC_HIT;
            default : state <= IC_IDLE;
        endcase
    end
end

always_ff @(posedge CLK)
begin
    if (accept)
        addr_q <= IF_ADDR;
end

cache_line #(.elem_t(cache_pkg::nibble_t), .tag_t(cache_pkg::ic_tag_t)) u_line
(
    .CLK        (CLK),
    .RES        (RES),
    .req_tag    (IF_ADDR[15:cache_pkg::IC_OFS_W]),
    .hit        (hit),
    .valid      (),
    .tag        (),
    .offset     (addr_q[cache_pkg::IC_OFS_W-1:0]),
    .load       (ic_fill_done),
    .load_tag   (addr_q[15:cache_pkg::IC_OFS_W]),
    .load_line  (fill_line),
    .merge      (1'b0),
    .merge_elem ('0),
    .line       (),
    .elem       (elem)
);

// Two codes per bus byte, code region in the lower half
assign ic_fill_req  = (state == IC_WAIT);
assign ic_fill_addr = {1'b0, addr_q[15:cache_pkg::IC_OFS_W], 2'b00};

assign IF_RDY  = (state == IC_HIT);
assign IF_CODE = IF_RDY ? elem : cache_pkg::CODE_NOP;

endmodule

// ==== dcache_ctrl.sv ====
/* Write-allocate, write-back data port with one request outstanding.
   A valid line is always written back on replacement since there is no dirty bit. */
`timescale 1ns/10ps

module dcache_ctrl
(
    input  logic                CLK,
    input  logic                RES,
    input  logic                DM_REQ,
    input  logic                DM_WRITE,
    input  cache_pkg::dm_addr_t DM_ADDR,
    input  cache_pkg::byte_t    DM_WDATA,
    output cache_pkg::byte_t    DM_RDATA,
    output logic                DM_RDY,
    output logic                dc_fill_req,
    output bus_pkg::bus_addr_t  dc_fill_addr,
    output logic                dc_wb_req,
    output bus_pkg::bus_addr_t  dc_wb_addr,
    output cache_pkg::line_t    dc_wb_line,
    input  logic                dc_fill_done,
    input  cache_pkg::line_t    fill_line
);

typedef enum logic [1:0] {DC_IDLE, DC_HIT, DC_WAIT, DC_FILL} state_t;

state_t                               state;
logic                                 accept;
logic                                 hit;
logic                                 valid;
logic                                 merge;
logic                                 wb_q;
cache_pkg::dm_addr_t                  addr_q;
logic                                 wr_q;
cache_pkg::byte_t                     wdata_q;
cache_pkg::dc_tag_t                   line_tag;
logic [cache_pkg::DC_OFS_W-1:0]       offset;
cache_pkg::byte_t                     merge_elem;
cache_pkg::byte_t                     elem;

assign accept = (state == DC_IDLE) & DM_REQ;

// ========================================
// Control
// ========================================
always_ff @(posedge CLK, posedge RES)
begin
    if (RES)
    begin
        state <= DC_IDLE;
        wb_q  <= 1'b0;
    end
    else
    begin
        case (state)
            DC_IDLE :
                if (DM_REQ)
                begin
                    state <= hit ? DC_HIT : DC_WAIT;
                    // Old line goes out first if it holds anything
                    wb_q  <= ~hit & valid;
                end
            DC_HIT  : state <= DC_IDLE;
            DC_WAIT :
                if (dc_fill_done)
                begin
                    state <= DC_FILL;
                    wb_q  <= 1'b0;
                end
            DC_FILL : state <= DC_IDLE;
            default : state <= DC_IDLE;
        endcase
    end
end

// Captured request
always_ff @(posedge CLK)
begin
    if (accept)
    begin
        addr_q  <= DM_ADDR;
        wr_q    <= DM_WRITE;
        wdata_q <= DM_WDATA;
    end
end

// ========================================
// Line store
// ========================================
// Write hit merges on acceptance, write miss after the refill
assign offset     = (state == DC_IDLE) ? DM_ADDR[cache_pkg::DC_OFS_W-1:0]
                                       : addr_q[cache_pkg::DC_OFS_W-1:0];
assign merge_elem = (state == DC_IDLE) ? DM_WDATA : wdata_q;
assign merge      = (accept & DM_WRITE & hit) | ((state == DC_FILL) & wr_q);

cache_line #(.elem_t(cache_pkg::byte_t), .tag_t(cache_pkg::dc_tag_t)) u_line
(
    .CLK        (CLK),
    .RES        (RES),
    .req_tag    (DM_ADDR[14:cache_pkg::DC_OFS_W]),
    .hit        (hit),
    .valid      (valid),
    .tag        (line_tag),
    .offset     (offset),
    .load       (dc_fill_done),
    .load_tag   (addr_q[14:cache_pkg::DC_OFS_W]),
    .load_line  (fill_line),
    .merge      (merge),
    .merge_elem (merge_elem),
    .line       (dc_wb_line),
    .elem       (elem)
);

// ========================================
// Sequencer requests
// ========================================
assign dc_fill_req = (state == DC_WAIT);
assign dc_wb_req   = (state == DC_WAIT) & wb_q;

// Line bases in the data half of the bus
always_comb
begin
    dc_fill_addr = {1'b0, addr_q[14:cache_pkg::DC_OFS_W], 2'b00};
    dc_wb_addr   = {1'b0, line_tag, 2'b00};
    dc_fill_addr[bus_pkg::REGION_DATA] = 1'b1;
    dc_wb_addr[bus_pkg::REGION_DATA]   = 1'b1;
end

assign DM_RDY   = (state == DC_HIT) | (state == DC_FILL);
assign DM_RDATA = (DM_RDY & ~wr_q) ? elem : '0;

endmodule

// ==== bus_sequencer.sv ====
/* Runs one cache transaction at a time on the pipelined byte bus, data side first.
   Controller requests and addresses must stay stable until their done pulse. */
`timescale 1ns/10ps

module bus_sequencer
(
    input  logic               CLK,
    input  logic               RES,
    input  logic               ic_fill_req,
    input  bus_pkg::bus_addr_t ic_fill_addr,
    output logic               ic_fill_done,
    input  logic               dc_fill_req,
    input  bus_pkg::bus_addr_t dc_fill_addr,
    input  logic               dc_wb_req,
    input  bus_pkg::bus_addr_t dc_wb_addr,
    input  cache_pkg::line_t   dc_wb_line,
    output logic               dc_fill_done,
    output cache_pkg::line_t   fill_line,
    output logic               BUS_REQ,
    output logic               BUS_WRITE,
    output bus_pkg::bus_addr_t BUS_ADDR,
    output bus_pkg::bus_data_t BUS_WDATA,
    input  bus_pkg::bus_data_t BUS_RDATA,
    input  logic               BUS_RDY
);

logic               busy;
logic               own_dc;
logic               wb_q;
logic [3:0]         a_cnt;
logic [3:0]         d_cnt;
logic [3:0]         n_beats;
logic               d_vld;
logic               a_act;
logic               a_wr;
logic               d_wr;
logic               last_beat;
bus_pkg::beat_t     a_beat;
bus_pkg::beat_t     d_beat;
bus_pkg::bus_addr_t base;
logic [23:0]        rd_q;

// ========================================
// Beat bookkeeping
// ========================================
// Write-back beats come first, then the fill
assign n_beats   = wb_q ? 4'(2 * bus_pkg::BURST_LEN) : 4'(bus_pkg::BURST_LEN);
assign a_act     = busy & (a_cnt != n_beats);
assign a_beat    = a_cnt[1:0];
assign d_beat    = d_cnt[1:0];
assign a_wr      = wb_q & ~a_cnt[2];
assign d_wr      = wb_q & ~d_cnt[2];
assign last_beat = d_vld & (d_cnt == n_beats - 4'd1);

always_ff @(posedge CLK, posedge RES)
begin
    if (RES)
    begin
        busy   <= 1'b0;
        own_dc <= 1'b0;
        wb_q   <= 1'b0;
        a_cnt  <= 4'd0;
        d_cnt  <= 4'd0;
        d_vld  <= 1'b0;
    end
    else if (~busy)
    begin
        // Arbitrate only while idle
        if (dc_fill_req | ic_fill_req)
        begin
            busy   <= 1'b1;
            own_dc <= dc_fill_req;
            wb_q   <= dc_fill_req & dc_wb_req;
            a_cnt  <= 4'd0;
        end
    end
    else if (BUS_RDY)
    begin
        if (a_act)
            a_cnt <= a_cnt + 4'd1;
        // Address phase just taken becomes the data phase
        d_vld <= a_act;
        d_cnt <= a_cnt;
        if (last_beat)
            busy <= 1'b0;
    end
end

// ========================================
// Address phase
// ========================================
always_comb
begin
    if (own_dc)
        base = a_wr ? dc_wb_addr : dc_fill_addr;
    else
        base = ic_fill_addr;
end

assign BUS_REQ   = a_act;
assign BUS_WRITE = a_act & a_wr;
assign BUS_ADDR  = a_act ? {base[15:2], a_beat} : '0;

// ========================================
// Data phase
// ========================================
// Old line leaves one byte per beat, lowest byte first
assign BUS_WDATA = (d_vld & d_wr) ? dc_wb_line[d_beat*8 +: 8] : '0;

// First three read bytes wait here, the last comes straight from the bus
always_ff @(posedge CLK)
begin
    if (BUS_RDY & d_vld & ~d_wr)
    begin
        case (d_beat)
            2'd0    : rd_q[7:0]   <= BUS_RDATA;
            2'd1    : rd_q[15:8]  <= BUS_RDATA;
            2'd2    : rd_q[23:16] <= BUS_RDATA;
            default : ;
        endcase
    end
end

assign fill_line    = {BUS_RDATA, rd_q};
assign ic_fill_done = BUS_RDY & last_beat & ~own_dc;
assign dc_fill_done = BUS_RDY & last_beat &  own_dc;

// Bus holds everything while the slave inserts wait states
a_bus_hold : assert property (@(posedge CLK) disable iff (RES)
    (BUS_REQ && !BUS_RDY) |=>
        (BUS_REQ && $stable(BUS_WRITE) && $stable(BUS_ADDR) && $stable(BUS_WDATA)));

endmodule

// ==== cache_top.sv ====
/* Memory front end with one-line instruction and data caches on one external bus.
   Each CPU port keeps a single request outstanding. */
`timescale 1ns/10ps

module cache_top
(
    input  logic                CLK,
    input  logic                RES,
    // Fetch port
    input  logic                IF_REQ,
    input  cache_pkg::if_addr_t IF_ADDR,
    output cache_pkg::nibble_t  IF_CODE,
    output logic                IF_RDY,
    // Data port
    input  logic                DM_REQ,
    input  logic                DM_WRITE,
    input  cache_pkg::dm_addr_t DM_ADDR,
    input  cache_pkg::byte_t    DM_WDATA,
    output cache_pkg::byte_t    DM_RDATA,
    output logic                DM_RDY,
    // External bus
    output logic                BUS_REQ,
    output logic                BUS_WRITE,
    output bus_pkg::bus_addr_t  BUS_ADDR,
    output bus_pkg::bus_data_t  BUS_WDATA,
    input  bus_pkg::bus_data_t  BUS_RDATA,
    input  logic                BUS_RDY
);

logic               ic_fill_req;
bus_pkg::bus_addr_t ic_fill_addr;
logic               ic_fill_done;
logic               dc_fill_req;
bus_pkg::bus_addr_t dc_fill_addr;
logic               dc_wb_req;
bus_pkg::bus_addr_t dc_wb_addr;
cache_pkg::line_t   dc_wb_line;
logic               dc_fill_done;
cache_pkg::line_t   fill_line;

icache_ctrl u_icache
(
    .CLK          (CLK),
    .RES          (RES),
    .IF_REQ       (IF_REQ),
    .IF_ADDR      (IF_ADDR),
    .IF_CODE      (IF_CODE),
    .IF_RDY       (IF_RDY),
    .ic_fill_req  (ic_fill_req),
    .ic_fill_addr (ic_fill_addr),
    .ic_fill_done (ic_fill_done),
    .fill_line    (fill_line)
);

dcache_ctrl u_dcache
(
    .CLK          (CLK),
    .RES          (RES),
    .DM_REQ       (DM_REQ),
    .DM_WRITE     (DM_WRITE),
    .DM_ADDR      (DM_ADDR),
    .DM_WDATA     (DM_WDATA),
    .DM_RDATA     (DM_RDATA),
    .DM_RDY       (DM_RDY),
    .dc_fill_req  (dc_fill_req),
    .dc_fill_addr (dc_fill_addr),
    .dc_wb_req    (dc_wb_req),
    .dc_wb_addr   (dc_wb_addr),
    .dc_wb_line   (dc_wb_line),
    .dc_fill_done (dc_fill_done),
    .fill_line    (fill_line)
);

bus_sequencer u_seq
(
    .CLK          (CLK),
    .RES          (RES),
    .ic_fill_req  (ic_fill_req),
    .ic_fill_addr (ic_fill_addr),
    .ic_fill_done (ic_fill_done),
    .dc_fill_req  (dc_fill_req),
    .dc_fill_addr (dc_fill_addr),
    .dc_wb_req    (dc_wb_req),
    .dc_wb_addr   (dc_wb_addr),
    .dc_wb_line   (dc_wb_line),
    .dc_fill_done (dc_fill_done),
    .fill_line    (fill_line),
    .BUS_REQ      (BUS_REQ),
    .BUS_WRITE    (BUS_WRITE),
    .BUS_ADDR     (BUS_ADDR),
    .BUS_WDATA    (BUS_WDATA),
    .BUS_RDATA    (BUS_RDATA),
    .BUS_RDY      (BUS_RDY)
);

endmodule

// ==== tb_bus_memory.sv ====
/* Bus slave over 64 KB for the cache testbench, each byte starts as address low byte XOR high byte.
   Wait states come from the stall input and the slave reports any output change under wait. */
`timescale 1ns/10ps

module tb_bus_memory
(
    input  logic               CLK,
    input  logic               RES,
    input  logic               stall,
    input  logic               BUS_REQ,
    input  logic               BUS_WRITE,
    input  bus_pkg::bus_addr_t BUS_ADDR,
    input  bus_pkg::bus_data_t BUS_WDATA,
    output bus_pkg::bus_data_t BUS_RDATA,
    output logic               BUS_RDY,
    output int                 hold_errors
);

bus_pkg::bus_data_t mem [0:65535];
logic               pend_valid;
logic               pend_write;
bus_pkg::bus_addr_t pend_addr;
logic               waited;
logic               held_req;
logic               held_write;
bus_pkg::bus_addr_t held_addr;
bus_pkg::bus_data_t held_wdata;

initial
begin
    int a;
    hold_errors = 0;
    for (a = 0; a < 65536; a++)
        mem[a] = a[7:0] ^ a[15:8];
end

assign BUS_RDY   = ~stall;
assign BUS_RDATA = (pend_valid & ~pend_write) ? mem[pend_addr] : '0;

// Address phase taken on a ready edge becomes the data phase
always @(posedge CLK, posedge RES)
begin
    if (RES)
    begin
        pend_valid <= 1'b0;
        pend_write <= 1'b0;
        pend_addr  <= '0;
    end
    else if (BUS_RDY)
    begin
        if (pend_valid & pend_write)
            mem[pend_addr] <= BUS_WDATA;
        pend_valid <= BUS_REQ;
        pend_write <= BUS_WRITE;
        pend_addr  <= BUS_ADDR;
    end
end

// Outputs seen on a wait edge must come back unchanged on the next edge
always @(posedge CLK)
begin
    if (RES)
        waited <= 1'b0;
    else
    begin
        if (waited && (BUS_REQ !== held_req || BUS_WRITE !== held_write ||
                       BUS_ADDR !== held_addr || BUS_WDATA !== held_wdata))
        begin
            hold_errors++;
            $display("%0t: bus outputs changed during a wait state", $time);
        end
        waited     <= ~BUS_RDY & (BUS_REQ | pend_valid);
        held_req   <= BUS_REQ;
        held_write <= BUS_WRITE;
        held_addr  <= BUS_ADDR;
        held_wdata <= BUS_WDATA;
    end
end

endmodule

// ==== tb_cache_top.sv ====
/* Random fetch and data traffic against a byte mirror of bus memory, fixed LFSR seed.
   Each port keeps one request outstanding, bus wait states are capped at MAX_WAIT in a row. */
`timescale 1ns/10ps

module tb_cache_top;

localparam int N_FETCH  = 200;
localparam int N_DATA   = 200;
localparam int MAX_WAIT = 2;
// Data miss with write-back, then a fetch fill queued behind it, every beat at the wait limit
localparam int MISS_CYCLES    = 2 * (2 * bus_pkg::BURST_LEN + 1) * (MAX_WAIT + 1) + 8;
localparam int TIMEOUT_CYCLES = (N_FETCH + N_DATA) * MISS_CYCLES + 20;
// Middle address bits shared by the small set of lines in use
localparam logic [10:0] IF_MID = 11'h2c9;
localparam logic [10:0] DM_MID = 11'h1b3;

logic                CLK;
logic                RES;
logic                IF_REQ;
cache_pkg::if_addr_t IF_ADDR;
cache_pkg::nibble_t  IF_CODE;
logic                IF_RDY;
logic                DM_REQ;
logic                DM_WRITE;
cache_pkg::dm_addr_t DM_ADDR;
cache_pkg::byte_t    DM_WDATA;
cache_pkg::byte_t    DM_RDATA;
logic                DM_RDY;
logic                BUS_REQ;
logic                BUS_WRITE;
bus_pkg::bus_addr_t  BUS_ADDR;
bus_pkg::bus_data_t  BUS_WDATA;
bus_pkg::bus_data_t  BUS_RDATA;
logic                BUS_RDY;
logic                stall;
int                  hold_errors;

// ========================================
// Model state
// ========================================
logic [31:0]         lfsr;
cache_pkg::byte_t    mirror [0:65535];
int                  tick;
int                  cycles;
int                  checks;
int                  value_errors;
int                  other_errors;
int                  wait_run;

logic                if_busy;
logic                if_gap;
logic                if_skipped;
logic                if_hit_exp;
logic                if_other_busy;
logic                if_last_valid;
cache_pkg::ic_tag_t  if_last_tag;
int                  if_issued;
int                  if_raise_tick;

logic                dm_busy;
logic                dm_gap;
logic                dm_skipped;
logic                dm_hit_exp;
logic                dm_other_busy;
logic                dm_last_valid;
cache_pkg::dc_tag_t  dm_last_tag;
int                  dm_issued;
int                  dm_raise_tick;

// Expected write-back beats, oldest first
bus_pkg::bus_addr_t  wb_addr_q [$];
cache_pkg::byte_t    wb_byte_q [$];
logic                first_pending;
bus_pkg::bus_addr_t  first_exp;
logic                mon_pend;
logic                mon_pend_wr;
bus_pkg::bus_addr_t  mon_pend_addr;

cache_top DUT
(
    .CLK       (CLK),
    .RES       (RES),
    .IF_REQ    (IF_REQ),
    .IF_ADDR   (IF_ADDR),
    .IF_CODE   (IF_CODE),
    .IF_RDY    (IF_RDY),
    .DM_REQ    (DM_REQ),
    .DM_WRITE  (DM_WRITE),
    .DM_ADDR   (DM_ADDR),
    .DM_WDATA  (DM_WDATA),
    .DM_RDATA  (DM_RDATA),
    .DM_RDY    (DM_RDY),
    .BUS_REQ   (BUS_REQ),
    .BUS_WRITE (BUS_WRITE),
    .BUS_ADDR  (BUS_ADDR),
    .BUS_WDATA (BUS_WDATA),
    .BUS_RDATA (BUS_RDATA),
    .BUS_RDY   (BUS_RDY)
);

tb_bus_memory u_mem
(
    .CLK         (CLK),
    .RES         (RES),
    .stall       (stall),
    .BUS_REQ     (BUS_REQ),
    .BUS_WRITE   (BUS_WRITE),
    .BUS_ADDR    (BUS_ADDR),
    .BUS_WDATA   (BUS_WDATA),
    .BUS_RDATA   (BUS_RDATA),
    .BUS_RDY     (BUS_RDY),
    .hold_errors (hold_errors)
);

initial
    CLK = 1'b0;

always #10 CLK = ~CLK;

// ========================================
// Random bits and compare tasks
// ========================================
// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

task automatic draw_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
        lfsr = lfsr_next(lfsr);
        v    = {v[30:0], lfsr[0]};
    end
endtask

task automatic compare_code(input cache_pkg::nibble_t got, input cache_pkg::nibble_t want,
                            input string what);
    checks++;
    if (got !== want)
    begin
        value_errors++;
        $display("Fail %0t: %s got %h expected %h", $time, what, got, want);
    end
endtask

task automatic compare_byte(input cache_pkg::byte_t got, input cache_pkg::byte_t want,
                            input string what);
    checks++;
    if (got !== want)
    begin
        value_errors++;
        $display("Fail %0t: %s got %h expected %h", $time, what, got, want);
    end
endtask

task automatic compare_bus_addr(input bus_pkg::bus_addr_t got, input bus_pkg::bus_addr_t want,
                                input string what);
    checks++;
    if (got !== want)
    begin
        value_errors++;
        $display("Fail %0t: %s got %h expected %h", $time, what, got, want);
    end
endtask

task automatic compare_flag(input logic got, input logic want, input string what);
    checks++;
    if (got !== want)
    begin
        value_errors++;
        $display("Fail %0t: %s got %b expected %b", $time, what, got, want);
    end
endtask

task automatic compare_cycles(input int got, input int want, input string what);
    checks++;
    if (got != want)
    begin
        value_errors++;
        $display("Fail %0t: %s got %0d expected %0d", $time, what, got, want);
    end
endtask

task automatic report_problem(input string msg);
    other_errors++;
    $display("%0t: %s", $time, msg);
endtask

// ========================================
// Port drivers
// ========================================
// About one cycle in four is a wait state
task automatic drive_wait();
    logic [31:0] bits;
    draw_bits(2, bits);
    if (bits[1:0] == 2'b00 && wait_run < MAX_WAIT)
    begin
        stall = 1'b1;
        wait_run++;
    end
    else
    begin
        stall    = 1'b0;
        wait_run = 0;
    end
endtask

// Hits answer one cycle after acceptance, misses need a refill
task automatic check_latency(input int lat, input logic hit_exp, input logic other_busy,
                             input string port);
    if (hit_exp)
    begin
        compare_cycles(lat, 1, {port, " hit latency"});
        if (!other_busy)
            compare_flag(BUS_REQ, 1'b0, {port, " hit bus request"});
    end
    else if (lat <= 1)
        report_problem($sformatf("%s miss answered after %0d cycle without a refill", port, lat));
endtask

task automatic finish_fetch();
    cache_pkg::byte_t   b;
    cache_pkg::nibble_t want;
    if (if_busy && IF_RDY)
    begin
        b    = mirror[{1'b0, IF_ADDR[15:1]}];
        want = IF_ADDR[0] ? b[7:4] : b[3:0];
        compare_code(IF_CODE, want, "fetch code");
        check_latency(tick - if_raise_tick, if_hit_exp, if_other_busy, "fetch");
        IF_REQ  = 1'b0;
        if_busy = 1'b0;
        if_gap  = 1'b1;
    end
    else if (IF_RDY)
        report_problem("IF_RDY pulsed with no fetch outstanding");
endtask

task automatic finish_data();
    if (dm_busy && DM_RDY)
    begin
        if (!DM_WRITE)
            compare_byte(DM_RDATA, mirror[{1'b1, DM_ADDR}], "data read");
        check_latency(tick - dm_raise_tick, dm_hit_exp, dm_other_busy, "data");
        DM_REQ  = 1'b0;
        dm_busy = 1'b0;
        dm_gap  = 1'b1;
    end
    else if (DM_RDY)
        report_problem("DM_RDY pulsed with no data access outstanding");
endtask

task automatic start_fetch(input logic other_busy);
    logic [31:0]         bits;
    cache_pkg::if_addr_t addr;
    if (if_busy || if_issued >= N_FETCH)
        return;
    // Port was answered last cycle
    if (if_gap)
    begin
        if_gap = 1'b0;
        return;
    end
    draw_bits(1, bits);
    if (!bits[0] && !if_skipped)
    begin
        if_skipped = 1'b1;
        return;
    end
    if_skipped = 1'b0;
    // Same line again or one of four lines
    draw_bits(1, bits);
    if (bits[0] && if_last_valid)
        addr[15:3] = if_last_tag;
    else
    begin
        draw_bits(2, bits);
        addr[15:3] = {bits[1:0], IF_MID};
    end
    draw_bits(3, bits);
    addr[2:0]     = bits[2:0];
    if_hit_exp    = if_last_valid && (if_last_tag == addr[15:3]);
    if_other_busy = other_busy;
    if_last_valid = 1'b1;
    if_last_tag   = addr[15:3];
    IF_REQ        = 1'b1;
    IF_ADDR       = addr;
    if_busy       = 1'b1;
    if_raise_tick = tick;
    if_issued++;
endtask

task automatic start_data(input logic other_busy);
    logic [31:0]         bits;
    cache_pkg::dm_addr_t addr;
    logic                wr;
    bus_pkg::bus_addr_t  base;
    int                  k;
    if (dm_busy || dm_issued >= N_DATA)
        return;
    if (dm_gap)
    begin
        dm_gap = 1'b0;
        return;
    end
    draw_bits(1, bits);
    if (!bits[0] && !dm_skipped)
    begin
        dm_skipped = 1'b1;
        return;
    end
    dm_skipped = 1'b0;
    draw_bits(1, bits);
    if (bits[0] && dm_last_valid)
        addr[14:2] = dm_last_tag;
    else
    begin
        draw_bits(2, bits);
        addr[14:2] = {bits[1:0], DM_MID};
    end
    draw_bits(2, bits);
    addr[1:0] = bits[1:0];
    draw_bits(1, bits);
    wr = bits[0];
    draw_bits(8, bits);
    dm_hit_exp    = dm_last_valid && (dm_last_tag == addr[14:2]);
    dm_other_busy = other_busy;
    // Replacing a valid line sends it out before the fill
    if (!dm_hit_exp && dm_last_valid)
    begin
        base = {1'b1, dm_last_tag, 2'b00};
        for (k = 0; k < bus_pkg::BURST_LEN; k++)
        begin
            wb_addr_q.push_back(bus_pkg::bus_addr_t'(base + k));
            wb_byte_q.push_back(mirror[bus_pkg::bus_addr_t'(base + k)]);
        end
    end
    if (wr)
        mirror[{1'b1, addr}] = bits[7:0];
    dm_last_valid = 1'b1;
    dm_last_tag   = addr[14:2];
    DM_REQ        = 1'b1;
    DM_WRITE      = wr;
    DM_ADDR       = addr;
    DM_WDATA      = bits[7:0];
    dm_busy       = 1'b1;
    dm_raise_tick = tick;
    dm_issued++;
endtask

// ========================================
// Bus monitor
// ========================================
always @(posedge CLK)
begin
    if (RES)
        mon_pend = 1'b0;
    else
    begin
        if (first_pending && BUS_REQ)
        begin
            compare_bus_addr(BUS_ADDR, first_exp, "first address after joint miss");
            first_pending = 1'b0;
        end
        if (BUS_RDY)
        begin
            // Write data phase completes on this edge
            if (mon_pend && mon_pend_wr)
            begin
                if (wb_addr_q.size() == 0)
                    report_problem("bus write with no write-back expected");
                else
                begin
                    compare_bus_addr(mon_pend_addr, wb_addr_q.pop_front(), "write-back address");
                    compare_byte(BUS_WDATA, wb_byte_q.pop_front(), "write-back data");
                end
            end
            mon_pend      = BUS_REQ;
            mon_pend_wr   = BUS_WRITE;
            mon_pend_addr = BUS_ADDR;
        end
    end
end

// ========================================
// Main sequence
// ========================================
initial
begin
    int   i;
    logic if_was_busy;
    logic dm_was_busy;
    RES      = 1'b1;
    IF_REQ   = 1'b0;
    IF_ADDR  = '0;
    DM_REQ   = 1'b0;
    DM_WRITE = 1'b0;
    DM_ADDR  = '0;
    DM_WDATA = '0;
    stall    = 1'b0;
    lfsr     = 32'he0f26a7f;
    tick          = 0;
    checks        = 0;
    value_errors  = 0;
    other_errors  = 0;
    wait_run      = 0;
    if_busy       = 1'b0;
    if_gap        = 1'b0;
    if_skipped    = 1'b0;
    if_last_valid = 1'b0;
    if_issued     = 0;
    dm_busy       = 1'b0;
    dm_gap        = 1'b0;
    dm_skipped    = 1'b0;
    dm_last_valid = 1'b0;
    dm_issued     = 0;
    first_pending = 1'b0;
    for (i = 0; i < 65536; i++)
        mirror[i] = i[7:0] ^ i[15:8];

    repeat (3) @(posedge CLK);
    @(negedge CLK);
    RES = 1'b0;

    // Nothing moves before the first request
    repeat (3)
    begin
        @(negedge CLK);
        compare_flag(IF_RDY, 1'b0, "IF_RDY after reset");
        compare_flag(DM_RDY, 1'b0, "DM_RDY after reset");
        compare_flag(BUS_REQ, 1'b0, "BUS_REQ after reset");
    end

    while (if_issued < N_FETCH || dm_issued < N_DATA || if_busy || dm_busy)
    begin
        @(negedge CLK);
        tick++;
        drive_wait();
        finish_fetch();
        finish_data();
        if_was_busy = if_busy;
        dm_was_busy = dm_busy;
        start_fetch(dm_was_busy);
        start_data(if_was_busy);
        // Both ports miss together with the sequencer idle, data side wins
        if (!if_was_busy && !dm_was_busy && if_busy && dm_busy && !if_hit_exp && !dm_hit_exp)
        begin
            first_pending = 1'b1;
            if (wb_addr_q.size() != 0)
                first_exp = wb_addr_q[0];
            else
                first_exp = {1'b1, DM_ADDR[14:2], 2'b00};
        end
    end

    repeat (2) @(negedge CLK);
    if (wb_addr_q.size() != 0)
        report_problem("expected write-back burst never appeared on the bus");
    if (first_pending)
        report_problem("no bus address seen after both ports missed");
    $display("checks %0d, value errors %0d, other errors %0d, bus hold errors %0d",
             checks, value_errors, other_errors, hold_errors);
    if (value_errors == 0 && other_errors == 0 && hold_errors == 0)
        $display("sim passed");
    else
        $display("sim failed");
    $finish;
end

// Run limit
initial
begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
        @(posedge CLK);
        cycles++;
    end
    $display("run stopped after %0d cycles without finishing", cycles);
    $display("sim failed");
    $finish;
end

endmodule

// ==== cache_top.f ====
cache_pkg.sv
bus_pkg.sv
cache_line.sv
icache_ctrl.sv
dcache_ctrl.sv
bus_sequencer.sv
cache_top.sv
tb_bus_memory.sv
tb_cache_top.sv

// ==== Bender.yml ====
package:
  name: cache_top

sources:
  - cache_pkg.sv
  - bus_pkg.sv
  - cache_line.sv
  - icache_ctrl.sv
  - dcache_ctrl.sv
  - bus_sequencer.sv
  - cache_top.sv
  - target: simulation
    files:
      - tb_bus_memory.sv
      - tb_cache_top.sv
